/* tb.f */
+incdir+rtl
rtl/pipe_pkg.sv
rtl/ctrl_pkg.sv
rtl/op_issue_ctrl.sv
rtl/preparer.sv
rtl/reg_file.sv
rtl/exec_stage.sv
rtl/mem_stage.sv
rtl/retire_counter.sv
rtl/op_pipe_top.sv
testbench/op_pipe_assertions.sv
testbench/op_pipe_tb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := op_pipe_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/op_pipe_tb.sv */
/*
  Testbench for the operand-preparation pipeline.
  Drives LFSR-built instructions through five tests and checks each retirement
  against an in-order model of the registers, data memory and retire count.
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module op_pipe_tb import pipe_pkg::*, ctrl_pkg::*; ();

    localparam int N_ALU   = 48;
    localparam int N_LOAD  = 24;   // Load and consumer pairs
    localparam int N_MEM   = 48;
    localparam int N_CSR   = 40;
    localparam int N_MIX   = 64;
    localparam int N_TOTAL = N_ALU + `DMEM_WORDS + 2 * N_LOAD + N_MEM + N_CSR + N_MIX;
    localparam int TIMEOUT_CYCLES = 8 * N_TOTAL + 50;

    // Instruction classes
    localparam int K_ALU_REG = 0;
    localparam int K_ALU_IMM = 1;
    localparam int K_LUI     = 2;
    localparam int K_LOAD    = 3;
    localparam int K_STORE   = 4;
    localparam int K_CSR_REG = 5;
    localparam int K_CSR_IMM = 6;
    localparam int K_JAL     = 7;

    typedef struct packed {
        logic  we;
        rf_add rd;
        word_t val;
    } exp_t;

    logic      clk, reset, instr_valid, instr_ready;
    logic      wb_valid, wb_we;
    op_instr_t instr;
    rf_add     wb_rd;
    word_t     wb_val;

    logic [15:0] lfsr;
    word_t       model_regs [8];            // Only x0..x7 are used
    word_t       model_mem [`DMEM_WORDS];
    exp_t        expected_q [$];            // Oldest first
    word_t       next_pc;
    int          accepted, checks, errors, errors_seen, cycles;

    op_pipe_top u_op_pipe_top (
        .clk_i(clk), .reset_i(reset), .instr_valid_i(instr_valid), .instr_i(instr),
        .instr_ready_o(instr_ready), .wb_valid_o(wb_valid), .wb_we_o(wb_we),
        .wb_rd_o(wb_rd), .wb_val_o(wb_val)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic op_instr_t make_instr(int kind);
        op_instr_t ins;
        ins         = '0;
        ins.rd      = rf_add'(take_bits(3));  // Few registers, many hazards
        ins.rs1     = rf_add'(take_bits(3));
        ins.rs2     = rf_add'(take_bits(3));
        ins.payload = payload_t'(take_bits(`PAYLOAD_W));
        case (kind)
            K_ALU_REG, K_ALU_IMM, K_LUI: begin
                ins.ictrl[ICTRL_REG_DEST] = 1'b1;
                ins.ictrl[ICTRL_UNIT_ALU] = 1'b1;
                ins.f = f_part'(take_bits(3) % 5);  // add to xor
                if (kind == K_ALU_REG) begin
                    ins.sctrl[SCTRL_RFRP1] = 1'b1;
                    ins.sctrl[SCTRL_RFRP2] = 1'b1;
                end else if (kind == K_ALU_IMM) begin
                    ins.ictrl[ICTRL_IMM]   = 1'b1;
                    ins.sctrl[SCTRL_RFRP1] = 1'b1;
                end else begin
                    ins.ictrl[ICTRL_LUI]   = 1'b1;
                    ins.sctrl[SCTRL_ZERO1] = 1'b1;  // Upper value plus zero
                    ins.f = f_part'(ALU_ADD);
                end
            end
            K_LOAD, K_STORE: begin
                ins.ictrl[ICTRL_UNIT_LSU] = 1'b1;
                ins.sctrl[SCTRL_RFRP1]    = 1'b1;
                if (take_bits(1) == 0) begin
                    ins.payload[11:0] = '0;  // Direct address half the time
                end
                if (kind == K_STORE) begin
                    ins.sctrl[SCTRL_RFRP2] = 1'b1;
                    ins.f = F_STORE;
                end else begin
                    ins.ictrl[ICTRL_REG_DEST] = 1'b1;
                end
            end
            K_CSR_REG, K_CSR_IMM: begin
                ins.ictrl[ICTRL_REG_DEST] = 1'b1;
                ins.ictrl[ICTRL_UNIT_CSR] = 1'b1;
                if (kind == K_CSR_IMM) begin
                    ins.f = F_CSR_IMM;
                end else begin
                    ins.sctrl[SCTRL_RFRP1] = 1'b1;
                end
            end
            default: begin
                ins.ictrl[ICTRL_REG_DEST] = 1'b1;  // Jump and link
                ins.ictrl[ICTRL_UNIT_BRU] = 1'b1;
            end
        endcase
        return ins;
    endfunction

    // Architectural effect of one accepted instruction, in order
    function automatic void apply_model(op_instr_t ins);
        word_t a, b, res, addr;
        exp_t  e;
        a   = ins.sctrl[SCTRL_ZERO1] ? '0 : model_regs[ins.rs1[2:0]];
        b   = model_regs[ins.rs2[2:0]];
        res = '0;
        if (ins.ictrl[ICTRL_UNIT_ALU]) begin
            if (ins.ictrl[ICTRL_LUI]) begin
                b = {ins.payload[19:0], 12'h000};
            end else if (ins.ictrl[ICTRL_IMM]) begin
                b = {{12{ins.payload[19]}}, ins.payload[19:0]};
            end
            case (alu_op_e'(ins.f))
                ALU_SUB: res = a - b;
                ALU_AND: res = a & b;
                ALU_OR:  res = a | b;
                ALU_XOR: res = a ^ b;
                default: res = a + b;
            endcase
        end else if (ins.ictrl[ICTRL_UNIT_LSU]) begin
            addr = a + {{20{ins.payload[11]}}, ins.payload[11:0]};
            if (ins.f == F_STORE) begin
                model_mem[addr[5:2]] = b;
            end else begin
                res = model_mem[addr[5:2]];
            end
        end else if (ins.ictrl[ICTRL_UNIT_CSR]) begin
            res = word_t'(accepted);  // Everything older has retired
        end else begin
            res = ins.pc + 32'd4;
        end
        e.we  = ins.ictrl[ICTRL_REG_DEST] && (ins.rd != '0);
        e.rd  = ins.rd;
        e.val = res;
        if (e.we) begin
            model_regs[ins.rd[2:0]] = res;
        end
        expected_q.push_back(e);
        accepted++;
    endfunction

    // Starts at a falling edge, holds valid and data until accepted
    task automatic issue(input op_instr_t ins);
        instr_valid = 1'b1;
        instr       = ins;
        instr.pc    = next_pc;
        while (!instr_ready) begin
            @(negedge clk);
        end
        apply_model(instr);  // Taken at the coming rising edge
        next_pc += 32'd4;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int n);
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        $display("%-22s %4d instructions, %0d errors", name, n, errors - errors_seen);
        errors_seen = errors;
    endtask

    // WB outputs are registered, stable at the falling edge
    always @(negedge clk) begin : check_retire
        exp_t e;
        if (!reset && wb_valid) begin
            if (expected_q.size() == 0) begin
                $display("Retirement at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                e = expected_q.pop_front();
                checks++;
                if ((wb_we !== e.we) || (e.we && ((wb_rd !== e.rd) || (wb_val !== e.val)))) begin
                    $display("[FAIL] %0t: retire %0d expected we=%0b x%0d=%h, got we=%0b x%0d=%h",
                             $time, checks, e.we, e.rd, e.val, wb_we, wb_rd, wb_val);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d instructions outstanding",
                     cycles, expected_q.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        op_instr_t ins, dep;
        int        pick, gap;
        lfsr        = 16'd46;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        next_pc     = 32'h0000_0100;
        accepted    = 0;
        checks      = 0;
        errors      = 0;
        errors_seen = 0;
        cycles      = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;  // Register file clears on reset
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (!instr_ready || wb_valid) begin
            $display("Ready low or WB valid high right after reset");
            errors++;
        end

        for (int i = 0; i < N_ALU; i++) begin
            pick = int'(take_bits(2));
            issue(make_instr(pick == 3 ? K_LUI : (pick == 2 ? K_ALU_IMM : K_ALU_REG)));
        end
        finish_test("ALU back-to-back", N_ALU);

        // Known contents in every word before the first load
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            ins = make_instr(K_STORE);
            ins.rs1 = '0;
            ins.payload[11:0] = 12'(4 * i);
            issue(ins);
        end
        for (int i = 0; i < N_LOAD; i++) begin
            ins = make_instr(K_LOAD);
            dep = make_instr(K_ALU_REG);
            if (take_bits(1) == 1) begin
                dep.rs1 = ins.rd;
            end else begin
                dep.rs2 = ins.rd;
            end
            issue(ins);
            issue(dep);  // Consumer right behind the load
        end
        finish_test("Load-use", `DMEM_WORDS + 2 * N_LOAD);

        for (int i = 0; i < N_MEM; i++) begin
            pick = int'(take_bits(2));
            issue(make_instr(pick == 0 ? K_ALU_IMM : (pick == 1 ? K_STORE : K_LOAD)));
        end
        finish_test("Stores and addresses", N_MEM);

        for (int i = 0; i < N_CSR; i++) begin
            pick = int'(take_bits(2));
            issue(make_instr(pick == 0 ? K_CSR_REG : (pick == 1 ? K_CSR_IMM :
                             (pick == 2 ? K_JAL : K_ALU_REG))));
        end
        finish_test("CSR and link", N_CSR);

        for (int i = 0; i < N_MIX; i++) begin
            ins = make_instr(int'(take_bits(3)));
            ins.fixed = (take_bits(2) == 0);
            gap = int'(take_bits(2));
            repeat (gap) @(negedge clk);  // Source idle
            issue(ins);
        end
        finish_test("Fixed and back-pressure", N_MIX);

        $display("Totals: %0d retirements checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/op_pipe_assertions.sv */
/*
  Concurrent checks on the pipeline top, attached to op_pipe_top with bind.
  Covers x0 writes, stall behavior at the source and quiet outputs after reset.
*/
`timescale 1ns/1ps

module op_pipe_assertions import pipe_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      instr_ready_i,
    input  logic      op_valid_i,     // OP register occupied
    input  logic      bubble_i,       // Preparer stall
    input  op_instr_t op_instr_i,     // ID/OP register contents
    input  logic      wb_valid_i,
    input  word_t     x0_i            // Register file entry x0
);

    // Register x0 storage never takes a WB write
    x0_stays_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        x0_i == '0)
        else $error("Register x0 holds a non-zero value");

    // A held instruction blocks the source and stays in OP unchanged
    stall_keeps_op: assert property (@(posedge clk_i) disable iff (reset_i)
        (op_valid_i && bubble_i) |=> (op_valid_i && $stable(op_instr_i)))
        else $error("Stalled instruction left OP or was overwritten");

    // First cycle out of reset
    quiet_after_reset: assert property (@(posedge clk_i)
        ($past(reset_i) && !reset_i) |-> (!wb_valid_i && instr_ready_i))
        else $error("Outputs active right after reset");

endmodule

bind op_pipe_top op_pipe_assertions u_op_pipe_assertions (
    .clk_i, .reset_i, .instr_ready_i(instr_ready_o), .op_valid_i(op_valid),
    .bubble_i(bubble), .op_instr_i(op_instr), .wb_valid_i(wb_valid_o),
    .x0_i(u_reg_file.regs[0])
);

/* rtl/op_pipe_top.sv */
/*
  Pipeline top, issue and OP, EX, MA and WB stages.
  Accepts decoded descriptors on a valid/ready pair and reports each retirement.
*/
`timescale 1ns/1ps

module op_pipe_top import pipe_pkg::*, ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      instr_valid_i,
    input  op_instr_t instr_i,
    output logic      instr_ready_o,
    output logic      wb_valid_o,    // One pulse per retirement
    output logic      wb_we_o,
    output rf_add     wb_rd_o,
    output word_t     wb_val_o
);

    logic       op_valid, bubble;
    op_instr_t  op_instr;
    rf_add      rs1, rs2;
    word_t      p1, p2, ma_addr, ma_wdata, retired;
    ex_bundle_t ex_bundle;
    stage_tag_t ex_tag, ma_in, ma_tag, wb_tag;

    op_issue_ctrl u_op_issue_ctrl (
        .clk_i, .reset_i, .instr_valid_i, .instr_i,
        .bubble_i(bubble), .instr_ready_o, .op_valid_o(op_valid), .op_instr_o(op_instr)
    );

    preparer u_preparer (
        .op_valid_i(op_valid), .op_instr_i(op_instr), .p1_i(p1), .p2_i(p2),
        .ex_tag_i(ex_tag), .ma_tag_i(ma_tag), .wb_tag_i(wb_tag),
        .rs1_o(rs1), .rs2_o(rs2), .ex_o(ex_bundle), .bubble_o(bubble)
    );

    reg_file u_reg_file (
        .clk_i, .reset_i, .rs1_i(rs1), .rs2_i(rs2), .we_i(wb_we_o),
        .rd_i(wb_tag.rd), .wd_i(wb_tag.val), .p1_o(p1), .p2_o(p2)
    );

    exec_stage u_exec_stage (
        .clk_i, .reset_i, .ex_i(ex_bundle), .ma_val_i(ma_tag.val), .wb_val_i(wb_tag.val),
        .ex_tag_o(ex_tag), .ma_in_o(ma_in), .ma_addr_o(ma_addr), .ma_wdata_o(ma_wdata)
    );

    mem_stage u_mem_stage (
        .clk_i, .reset_i, .ma_in_i(ma_in), .ma_addr_i(ma_addr), .ma_wdata_i(ma_wdata),
        .retired_i(retired), .ma_tag_o(ma_tag), .wb_tag_o(wb_tag)
    );

    retire_counter u_retire_counter (
        .clk_i, .reset_i, .retire_i(wb_valid_o), .count_o(retired)
    );

    // WB slot decode
    assign wb_valid_o = (wb_tag.ictrl != '0);
    assign wb_we_o    = wb_tag.ictrl[ICTRL_REG_DEST] & (wb_tag.rd != '0);
    assign wb_rd_o    = wb_tag.rd;
    assign wb_val_o   = wb_tag.val;

endmodule

/* rtl/retire_counter.sv */
/*
  Count of retired instructions, read by CSR instructions in MA.
*/
`timescale 1ns/1ps

module retire_counter import pipe_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  retire_i,   // Non-empty WB slot
    output word_t count_o
);

    word_t count_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (retire_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

endmodule

/* rtl/mem_stage.sv */
/*
  MA stage with the data memory and the MA/WB register.
  Stores write and loads read a word; CSR and BRU results are substituted here.
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module mem_stage import pipe_pkg::*, ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  stage_tag_t ma_in_i,
    input  word_t      ma_addr_i,
    input  word_t      ma_wdata_i,  // Store data or link address
    input  word_t      retired_i,   // Retire counter
    output stage_tag_t ma_tag_o,
    output stage_tag_t wb_tag_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    word_t            dmem [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             is_store;
    word_t            csr_val, ma_val;
    stage_tag_t       wb_q;

    assign idx      = ma_addr_i[IDX_W+1:2];  // Word index
    assign is_store = ma_in_i.ictrl[ICTRL_UNIT_LSU] & (ma_in_i.f == F_STORE);
    assign csr_val  = retired_i + word_t'(wb_q.ictrl != '0);  // WB slot retires now

    always_ff @(posedge clk_i) begin
        if (is_store) begin
            dmem[idx] <= ma_wdata_i;
        end
    end

    always_comb begin
        if (ma_in_i.ictrl[ICTRL_UNIT_LSU]) begin
            ma_val = dmem[idx];    // Ignored for stores
        end else if (ma_in_i.ictrl[ICTRL_UNIT_CSR]) begin
            ma_val = csr_val;
        end else if (ma_in_i.ictrl[ICTRL_UNIT_BRU]) begin
            ma_val = ma_wdata_i;   // pc+4
        end else begin
            ma_val = ma_in_i.val;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_q.ictrl <= '0;
        end else begin
            wb_q <= '{rd: ma_in_i.rd, ictrl: ma_in_i.ictrl, f: ma_in_i.f, val: ma_val};
        end
    end

    assign ma_tag_o = ma_in_i;  // Raw value for forwarding
    assign wb_tag_o = wb_q;

endmodule

/* rtl/exec_stage.sv */
/*
  EX stage with the OP/EX and EX/MA registers.
  Applies late forwarding, runs the ALU and passes the LSU address and store data to MA.
*/
`timescale 1ns/1ps

module exec_stage import pipe_pkg::*, ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  ex_bundle_t ex_i,
    input  word_t      ma_val_i,    // Raw EX/MA result
    input  word_t      wb_val_i,    // Final MA/WB result
    output stage_tag_t ex_tag_o,
    output stage_tag_t ma_in_o,
    output word_t      ma_addr_o,
    output word_t      ma_wdata_o
);

    ex_bundle_t opex_q;
    stage_tag_t exma_q;
    word_t      op1, op2, alu_res, result;
    word_t      addr_q, wdata_q;

    // MA producer is newer than WB
    assign op1 = opex_q.fwd[0] ? ma_val_i : (opex_q.fwd[2] ? wb_val_i : opex_q.operand1);
    assign op2 = opex_q.fwd[1] ? ma_val_i : (opex_q.fwd[3] ? wb_val_i : opex_q.operand2);

    always_comb begin
        case (alu_op_e'(opex_q.f))
            ALU_SUB: alu_res = op1 - op2;
            ALU_AND: alu_res = op1 & op2;
            ALU_OR:  alu_res = op1 | op2;
            ALU_XOR: alu_res = op1 ^ op2;
            default: alu_res = op1 + op2;  // ADD, LUI
        endcase
    end

    assign result   = opex_q.ictrl[ICTRL_UNIT_ALU] ? alu_res : op1;  // Else LSU address
    assign ex_tag_o = '{rd: opex_q.rd, ictrl: opex_q.ictrl, f: opex_q.f, val: result};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            opex_q.ictrl <= '0;
            exma_q.ictrl <= '0;
        end else begin
            opex_q <= ex_i;       // Advances every cycle
            exma_q <= ex_tag_o;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q  <= op1;
        wdata_q <= opex_q.ictrl[ICTRL_UNIT_BRU] ? opex_q.sdata : op2;  // Link or store data
    end

    assign ma_in_o    = exma_q;
    assign ma_addr_o  = addr_q;
    assign ma_wdata_o = wdata_q;

endmodule

/* rtl/reg_file.sv */
/*
  Integer register file, two asynchronous reads and one synchronous write.
  Register x0 reads as zero and is never written.
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file import pipe_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  rf_add rs1_i,
    input  rf_add rs2_i,
    input  logic  we_i,
    input  rf_add rd_i,
    input  word_t wd_i,
    output word_t p1_o,
    output word_t p2_o
);

    localparam int RF_WORDS = 1 << `RF_ADDR_W;

    word_t regs [RF_WORDS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < RF_WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    // Old value on a same-cycle write, WB forwarding covers it
    assign p1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign p2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* rtl/preparer.sv */
/*
  OP stage operand preparation.
  Detects hazards against EX, MA and WB, forwards early values, computes the
  LSU address and selects both operands for EX.
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module preparer import pipe_pkg::*, ctrl_pkg::*; (
    input  logic       op_valid_i,  // OP register holds an instruction
    input  op_instr_t  op_instr_i,
    input  word_t      p1_i,        // Register file port 1
    input  word_t      p2_i,        // Register file port 2
    input  stage_tag_t ex_tag_i,    // OP/EX contents
    input  stage_tag_t ma_tag_i,    // EX/MA contents, raw result
    input  stage_tag_t wb_tag_i,    // MA/WB contents, final result
    output rf_add      rs1_o,
    output rf_add      rs2_o,
    output ex_bundle_t ex_o,
    output logic       bubble_o
);

    sctrl_t     sc;
    ictrl_t     ic;
    rf_add      rs1, rs2;
    word_t      op1_fw, op2_fw, offset, address, imm_sext, operand1, operand2;
    logic       rs1_need_ex, rs2_need_ex, rs1_need_ma, rs2_need_ma;
    logic       rs1_need_wb, rs2_need_wb, direct_addr, result_in_ma;
    logic       lsu_hazard, data_hazard, csr_hazard, link_hazard, fix_hazard;
    logic [3:0] fwd;

    // Read-after-write against one stage slot, x0 never matches
    function automatic logic raw(rf_add src, logic reads, stage_tag_t tag);
        return reads & (src != '0) & (tag.rd == src) & tag.ictrl[ICTRL_REG_DEST];
    endfunction

    assign sc    = op_instr_i.sctrl;
    assign ic    = op_instr_i.ictrl;
    assign rs1_o = op_instr_i.rs1;
    assign rs2_o = op_instr_i.rs2;
    assign rs1   = sc[SCTRL_ZERO1] ? '0 : op_instr_i.rs1;
    assign rs2   = sc[SCTRL_ZERO2] ? '0 : op_instr_i.rs2;

    assign rs1_need_ex = raw(rs1, sc[SCTRL_RFRP1], ex_tag_i);
    assign rs2_need_ex = raw(rs2, sc[SCTRL_RFRP2], ex_tag_i);
    assign rs1_need_ma = raw(rs1, sc[SCTRL_RFRP1], ma_tag_i);
    assign rs2_need_ma = raw(rs2, sc[SCTRL_RFRP2], ma_tag_i);
    assign rs1_need_wb = raw(rs1, sc[SCTRL_RFRP1], wb_tag_i);
    assign rs2_need_wb = raw(rs2, sc[SCTRL_RFRP2], wb_tag_i);

    assign direct_addr  = (op_instr_i.payload[11:0] == '0);  // Zero offset
    assign result_in_ma = ma_tag_i.ictrl[ICTRL_UNIT_LSU] | ma_tag_i.ictrl[ICTRL_UNIT_CSR]
                        | ma_tag_i.ictrl[ICTRL_UNIT_BRU];      // Raw MA value not final

    // Address needs a final base in OP
    assign lsu_hazard  = ic[ICTRL_UNIT_LSU] & ~direct_addr
                       & (rs1_need_ex | (rs1_need_ma & result_in_ma));
    // Load data only appears in MA
    assign data_hazard = (rs1_need_ex | rs2_need_ex) & ex_tag_i.ictrl[ICTRL_UNIT_LSU]
                       & (ex_tag_i.f != F_STORE);
    assign csr_hazard  = (rs1_need_ex | rs2_need_ex) & ex_tag_i.ictrl[ICTRL_UNIT_CSR];
    assign link_hazard = (rs1_need_ex | rs2_need_ex) & ex_tag_i.ictrl[ICTRL_UNIT_BRU];
    assign fix_hazard  = op_instr_i.fixed
                       & ((ex_tag_i.ictrl != '0) | (ma_tag_i.ictrl != '0));
    assign bubble_o    = op_valid_i
                       & (lsu_hazard | data_hazard | csr_hazard | link_hazard | fix_hazard);

    // Early forwarding, newest first
    assign op1_fw = rs1_need_ma ? ma_tag_i.val :
                    rs1_need_wb ? wb_tag_i.val :
                    sc[SCTRL_ZERO1] ? '0 : p1_i;
    assign op2_fw = rs2_need_wb ? wb_tag_i.val :
                    sc[SCTRL_ZERO2] ? '0 : p2_i;

    // Late forwarding requests for EX
    assign fwd[0] = rs1_need_ex;
    assign fwd[1] = rs2_need_ex;
    assign fwd[2] = rs1_need_ma & (~ic[ICTRL_UNIT_LSU] | direct_addr);  // Not once added
    assign fwd[3] = rs2_need_ma;

    assign offset   = {{(`XLEN-12){op_instr_i.payload[11]}}, op_instr_i.payload[11:0]};
    assign address  = op1_fw + offset;
    assign imm_sext = {{(`XLEN-20){op_instr_i.payload[19]}}, op_instr_i.payload[19:0]};

    always_comb begin
        if (ic[ICTRL_UNIT_LSU]) begin
            operand1 = address;
        end else if (ic[ICTRL_UNIT_CSR] & (op_instr_i.f == F_CSR_IMM)) begin
            operand1 = {{(`XLEN-5){1'b0}}, op_instr_i.payload[15:11]};  // CSR immediate
        end else begin
            operand1 = op1_fw;  // Register, zero for LUI
        end
    end

    always_comb begin
        if (ic[ICTRL_LUI]) begin
            operand2 = {op_instr_i.payload[19:0], 12'b0};
        end else if (ic[ICTRL_IMM]) begin
            operand2 = imm_sext;
        end else begin
            operand2 = op2_fw;  // Register or store data
        end
    end

    assign ex_o = '{
        rd:       op_instr_i.rd,
        ictrl:    (op_valid_i & ~bubble_o) ? ic : '0,  // Empty slot on bubble
        f:        op_instr_i.f,
        operand1: operand1,
        operand2: operand2,
        sdata:    ic[ICTRL_UNIT_BRU] ? op_instr_i.pc + 'd4 : op2_fw,
        fwd:      fwd
    };

endmodule

/* rtl/op_issue_ctrl.sv */
/*
  Issue control in front of the operand-preparation stage.
  Accepts one descriptor per strobe into the ID/OP register and holds it on a bubble.
*/
`timescale 1ns/1ps

module op_issue_ctrl import pipe_pkg::*, ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      instr_valid_i,   // Source strobe
    input  op_instr_t instr_i,
    input  logic      bubble_i,        // Preparer holds OP
    output logic      instr_ready_o,
    output logic      op_valid_o,
    output op_instr_t op_instr_o
);

    issue_state_e state_q, state_d;
    op_instr_t    instr_q;             // ID/OP register
    logic         accept;

    assign op_valid_o    = (state_q != ST_EMPTY);
    assign instr_ready_o = ~op_valid_o | ~bubble_i;  // Free or advancing now
    assign accept        = instr_valid_i & instr_ready_o;
    assign op_instr_o    = instr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_EMPTY: begin
                if (accept) begin
                    state_d = ST_ISSUE;
                end
            end
            default: begin
                // Holding an instruction
                if (bubble_i) begin
                    state_d = ST_STALL;
                end else if (accept) begin
                    state_d = ST_ISSUE;  // Refilled in the same cycle
                end else begin
                    state_d = ST_EMPTY;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Descriptor only, validity lives in the state
    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q <= instr_i;
        end
    end

endmodule

/* rtl/ctrl_pkg.sv */
/*
  Control encodings of the pipeline.
  Bit positions of ictrl and sctrl, the ALU function enum and the issue FSM states.
*/
`include "core_macros.svh"

package ctrl_pkg;

    // Instruction control bits
    localparam int ICTRL_REG_DEST = 0;  // Writes rd
    localparam int ICTRL_UNIT_ALU = 1;
    localparam int ICTRL_UNIT_LSU = 2;
    localparam int ICTRL_UNIT_CSR = 3;  // Reads retire count
    localparam int ICTRL_UNIT_BRU = 4;  // Jump and link
    localparam int ICTRL_IMM      = 5;  // Immediate operand 2
    localparam int ICTRL_LUI      = 6;  // Upper immediate operand 2

    // Source control bits
    localparam int SCTRL_RFRP1 = 0;     // Reads rs1
    localparam int SCTRL_RFRP2 = 1;     // Reads rs2
    localparam int SCTRL_ZERO1 = 2;     // Operand 1 forced to zero
    localparam int SCTRL_ZERO2 = 3;

    // Function value 3 outside the ALU
    localparam logic [`F_W-1:0] F_STORE   = 3;  // LSU store, else load
    localparam logic [`F_W-1:0] F_CSR_IMM = 3;  // CSR immediate form

    typedef enum logic [`F_W-1:0] {
        ALU_ADD = 0,
        ALU_SUB = 1,
        ALU_AND = 2,
        ALU_OR  = 3,
        ALU_XOR = 4
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_EMPTY,   // OP register free
        ST_ISSUE,   // Holding, expected to advance
        ST_STALL    // Holding under bubble
    } issue_state_e;

endpackage

/* rtl/pipe_pkg.sv */
/*
  Data types carried between the pipeline stages.
  Holds the accepted descriptor, the OP to EX bundle and the stage tags.
*/
`include "core_macros.svh"

package pipe_pkg;

    typedef logic [`RF_ADDR_W-1:0] rf_add;     // Register address
    typedef logic [`XLEN-1:0]      word_t;     // Data word
    typedef logic [`PAYLOAD_W-1:0] payload_t;  // Immediate, CSR immediate in 15:11
    typedef logic [`ICTRL_W-1:0]   ictrl_t;    // Bit names in ctrl_pkg
    typedef logic [`SCTRL_W-1:0]   sctrl_t;
    typedef logic [`F_W-1:0]       f_part;

    // Decoded instruction as accepted from the source
    typedef struct packed {
        word_t    pc;
        rf_add    rd;
        rf_add    rs1;
        rf_add    rs2;
        payload_t payload;
        f_part    f;
        ictrl_t   ictrl;
        sctrl_t   sctrl;
        logic     fixed;      // Waits for empty EX and MA
    } op_instr_t;

    // OP to EX, ictrl of zero marks an empty slot
    typedef struct packed {
        rf_add    rd;
        ictrl_t   ictrl;
        f_part    f;
        word_t    operand1;   // Address for LSU
        word_t    operand2;   // Store data for stores
        word_t    sdata;      // Early store data, link address for BRU
        logic [3:0] fwd;      // 0,1 MA result; 2,3 WB result
    } ex_bundle_t;

    // What a stage slot holds
    typedef struct packed {
        rf_add    rd;
        ictrl_t   ictrl;
        f_part    f;
        word_t    val;
    } stage_tag_t;

endpackage

/* rtl/core_macros.svh */
/*
  Widths and sizes shared by the pipeline packages and RTL modules.
  Include wherever a width macro is needed; the guard makes repeats harmless.
*/
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define XLEN        32  // Data word
`define RF_ADDR_W   5   // Register address, 32 registers
`define PAYLOAD_W   21  // Immediate field of the descriptor

// Control field widths
`define ICTRL_W     7   // Unit and destination flags
`define SCTRL_W     4   // Source flags
`define F_W         4   // Function code

`define DMEM_WORDS  16  // Data memory, word addressed

`endif
